// ==== design/acc_core.sv ====
// Single accumulator lane executing one opcode per valid cycle

`timescale 1ns/1ps

module acc_core (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   op_valid_i,
  input  lockstep_pkg::acc_op_e  op_i,
  input  lockstep_pkg::acc_data_t operand_i,
  output logic                   res_valid_o,
  output lockstep_pkg::acc_data_t res_o
);

  lockstep_pkg::acc_data_t acc_d;
  lockstep_pkg::acc_data_t acc_q;
  logic                    valid_q;

  ////////////////////////////////////////////////////////////////////////////
  // Next accumulator value
  ////////////////////////////////////////////////////////////////////////////

  // Arithmetic wraps at the word width
  always_comb begin
    case (op_i)
      lockstep_pkg::OP_CLR:  acc_d = '0;
      lockstep_pkg::OP_LOAD: acc_d = operand_i;
      lockstep_pkg::OP_ADD:  acc_d = acc_q + operand_i;
      lockstep_pkg::OP_SUB:  acc_d = acc_q - operand_i;
      lockstep_pkg::OP_AND:  acc_d = acc_q & operand_i;
      lockstep_pkg::OP_XOR:  acc_d = acc_q ^ operand_i;
      // Unused codes hold the value
      default:               acc_d = acc_q;
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // Registers
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      acc_q   <= '0;
      valid_q <= 1'b0;
    end else begin
      valid_q <= op_valid_i;
      if (op_valid_i) begin
        acc_q <= acc_d;
      end
    end
  end

  // Result is the accumulator itself, one cycle after acceptance
  assign res_valid_o = valid_q;
  assign res_o       = acc_q;

  ////////////////////////////////////////////////////////////////////////////
  // Assertions
  ////////////////////////////////////////////////////////////////////////////

  // Only defined opcodes may arrive with valid
  a_known_opcode : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    op_valid_i |-> (op_i inside {lockstep_pkg::OP_CLR, lockstep_pkg::OP_LOAD,
                                 lockstep_pkg::OP_ADD, lockstep_pkg::OP_SUB,
                                 lockstep_pkg::OP_AND, lockstep_pkg::OP_XOR})
  ) else $error("acc_core: unused opcode %0d accepted", op_i);

endmodule

// ==== design/lockstep_compare.sv ====
// Main output delay line, shadow output register, self-test flip and mismatch alert

`timescale 1ns/1ps

`include "lockstep_settings.svh"

module lockstep_compare (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    cmp_enable_i,
  input  logic                    fault_inject_i,
  input  logic                    lane_res_valid_i [`NUM_LANES],
  input  lockstep_pkg::acc_data_t lane_res_i       [`NUM_LANES],
  output logic                    alert_o
);

  // One extra stage covers the shadow output register
  localparam int unsigned OUT_DEPTH = `LOCKSTEP_OFFSET + 1;

  logic                    main_valid_q [OUT_DEPTH];
  lockstep_pkg::acc_data_t main_res_q   [OUT_DEPTH];
  logic                    shadow_valid_q;
  lockstep_pkg::acc_data_t shadow_res_q;
  lockstep_pkg::acc_data_t flip_mask;
  logic                    valid_mismatch;
  logic                    res_mismatch;

  ////////////////////////////////////////////////////////////////////////////
  // Main lane delay
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < OUT_DEPTH; i++) begin
        main_valid_q[i] <= 1'b0;
        main_res_q[i]   <= '0;
      end
    end else begin
      main_valid_q[0] <= lane_res_valid_i[0];
      main_res_q[0]   <= lane_res_i[0];
      for (int i = 1; i < OUT_DEPTH; i++) begin
        main_valid_q[i] <= main_valid_q[i-1];
        main_res_q[i]   <= main_res_q[i-1];
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Shadow lane register
  ////////////////////////////////////////////////////////////////////////////

  // Self-test corrupts bit 0 of one captured result
  assign flip_mask = {{(`DATA_W-1){1'b0}}, fault_inject_i};

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      shadow_valid_q <= 1'b0;
      shadow_res_q   <= '0;
    end else begin
      shadow_valid_q <= lane_res_valid_i[1];
      shadow_res_q   <= lane_res_i[1] ^ flip_mask;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Comparison
  ////////////////////////////////////////////////////////////////////////////

  assign valid_mismatch = main_valid_q[OUT_DEPTH-1] != shadow_valid_q;
  assign res_mismatch   = main_res_q[OUT_DEPTH-1] != shadow_res_q;

  assign alert_o = cmp_enable_i & (valid_mismatch | res_mismatch);

  // Self-test pulse must show up as an alert in the following cycle
  a_self_test_alert : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    (cmp_enable_i && fault_inject_i) |=> alert_o
  ) else $error("lockstep_compare: self-test pulse raised no alert");

endmodule

// ==== design/lockstep_pkg.sv ====
// Opcode enum and data type shared by the lockstep accumulator

`include "lockstep_settings.svh"

package lockstep_pkg;

  // Accumulator operations
  // Codes 6 and 7 are unused and leave the accumulator unchanged
  typedef enum logic [`OP_W-1:0] {
    OP_CLR,
    OP_LOAD,
    OP_ADD,
    OP_SUB,
    OP_AND,
    OP_XOR
  } acc_op_e;

  // Operand, accumulator and result word
  typedef logic [`DATA_W-1:0] acc_data_t;

endpackage

// ==== design/lockstep_reset_ctrl.sv ====
// Post-reset counter, shadow lane reset release and comparison enable

`timescale 1ns/1ps

`include "lockstep_settings.svh"

module lockstep_reset_ctrl (
  input  logic clk_i,
  input  logic rst_ni,
  output logic shadow_rst_no,
  output logic cmp_enable_o
);

  localparam int unsigned CNT_W = $clog2(`LOCKSTEP_OFFSET);
  localparam logic [CNT_W-1:0] CNT_MAX = CNT_W'(`LOCKSTEP_OFFSET - 1);

  logic [CNT_W-1:0] cnt_q;
  logic             shadow_set_q;
  logic             cmp_en_q;

  // Counts from reset release and stops at OFFSET-1
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q <= '0;
    end else if (cnt_q != CNT_MAX) begin
      cnt_q <= cnt_q + 1'b1;
    end
  end

  // Shadow reset lifts one cycle after the count is reached,
  // comparison starts one cycle after that
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      shadow_set_q <= 1'b0;
      cmp_en_q     <= 1'b0;
    end else begin
      shadow_set_q <= (cnt_q == CNT_MAX);
      cmp_en_q     <= shadow_set_q;
    end
  end

  assign shadow_rst_no = shadow_set_q;
  assign cmp_enable_o  = cmp_en_q;

  ////////////////////////////////////////////////////////////////////////////
  // Assertions
  ////////////////////////////////////////////////////////////////////////////

  // Never compare while the shadow lane is still held in reset
  a_cmp_after_shadow : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    cmp_enable_o |-> shadow_rst_no
  ) else $error("lockstep_reset_ctrl: compare enabled with shadow lane in reset");

endmodule

// ==== design/lockstep_settings.svh ====
// Width, lockstep offset, lane count and opcode width macros for the lockstep accumulator

`ifndef LOCKSTEP_SETTINGS_SVH
`define LOCKSTEP_SETTINGS_SVH

////////////////////////////////////////////////////////////////////////////
// Datapath
////////////////////////////////////////////////////////////////////////////

// Operand and accumulator width
`define DATA_W 16

// Opcode field width, six codes used out of eight
`define OP_W 3

////////////////////////////////////////////////////////////////////////////
// Lockstep
////////////////////////////////////////////////////////////////////////////

// Cycles the shadow lane trails the main lane, must be at least 2
`define LOCKSTEP_OFFSET 2

// Lane 0 is the main lane, lane 1 the shadow
`define NUM_LANES 2

`endif

// ==== design/lockstep_stagger.sv ====
// Input delay line feeding the main lane live and the shadow lane delayed operations

`timescale 1ns/1ps

`include "lockstep_settings.svh"

module lockstep_stagger (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    op_valid_i,
  input  lockstep_pkg::acc_op_e   op_i,
  input  lockstep_pkg::acc_data_t operand_i,
  output logic                    lane_op_valid_o [`NUM_LANES],
  output lockstep_pkg::acc_op_e   lane_op_o       [`NUM_LANES],
  output lockstep_pkg::acc_data_t lane_operand_o  [`NUM_LANES]
);

  localparam int unsigned DEPTH = `LOCKSTEP_OFFSET;

  // Stage 0 is the newest entry, DEPTH-1 the oldest
  logic                    valid_q   [DEPTH];
  lockstep_pkg::acc_op_e   op_q      [DEPTH];
  lockstep_pkg::acc_data_t operand_q [DEPTH];

  ////////////////////////////////////////////////////////////////////////////
  // Shift register
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < DEPTH; i++) begin
        valid_q[i]   <= 1'b0;
        op_q[i]      <= lockstep_pkg::OP_CLR;
        operand_q[i] <= '0;
      end
    end else begin
      valid_q[0]   <= op_valid_i;
      op_q[0]      <= op_i;
      operand_q[0] <= operand_i;
      for (int i = 1; i < DEPTH; i++) begin
        valid_q[i]   <= valid_q[i-1];
        op_q[i]      <= op_q[i-1];
        operand_q[i] <= operand_q[i-1];
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Lane fan-out
  ////////////////////////////////////////////////////////////////////////////

  // Main lane sees the live stream
  assign lane_op_valid_o[0] = op_valid_i;
  assign lane_op_o[0]       = op_i;
  assign lane_operand_o[0]  = operand_i;

  // Shadow lanes take the oldest stage
  for (genvar l = 1; l < `NUM_LANES; l++) begin : g_shadow_feed
    assign lane_op_valid_o[l] = valid_q[DEPTH-1];
    assign lane_op_o[l]       = op_q[DEPTH-1];
    assign lane_operand_o[l]  = operand_q[DEPTH-1];
  end

endmodule

// ==== design/lockstep_top.sv ====
// Top level of the dual-lane lockstep accumulator

`timescale 1ns/1ps

`include "lockstep_settings.svh"

module lockstep_top (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    op_valid_i,
  input  lockstep_pkg::acc_op_e   op_i,
  input  lockstep_pkg::acc_data_t operand_i,
  input  logic                    fault_inject_i,
  output logic                    res_valid_o,
  output lockstep_pkg::acc_data_t res_o,
  output logic                    cmp_enable_o,
  output logic                    alert_o
);

  // Per-lane operation stream
  logic                    lane_op_valid [`NUM_LANES];
  lockstep_pkg::acc_op_e   lane_op       [`NUM_LANES];
  lockstep_pkg::acc_data_t lane_operand  [`NUM_LANES];

  // Per-lane results
  logic                    lane_res_valid [`NUM_LANES];
  lockstep_pkg::acc_data_t lane_res       [`NUM_LANES];

  logic shadow_rst_n;
  logic cmp_enable;

  ////////////////////////////////////////////////////////////////////////////
  // Input stagger
  ////////////////////////////////////////////////////////////////////////////

  lockstep_stagger u_stagger (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .op_valid_i      (op_valid_i),
    .op_i            (op_i),
    .operand_i       (operand_i),
    .lane_op_valid_o (lane_op_valid),
    .lane_op_o       (lane_op),
    .lane_operand_o  (lane_operand)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Reset sequencing
  ////////////////////////////////////////////////////////////////////////////

  lockstep_reset_ctrl u_reset_ctrl (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .shadow_rst_no (shadow_rst_n),
    .cmp_enable_o  (cmp_enable)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Lanes
  ////////////////////////////////////////////////////////////////////////////

  for (genvar i = 0; i < `NUM_LANES; i++) begin : g_lane
    logic lane_rst_n;

    // Main lane on the system reset, shadow on the staggered one
    assign lane_rst_n = (i == 0) ? rst_ni : shadow_rst_n;

    acc_core u_acc_core (
      .clk_i       (clk_i),
      .rst_ni      (lane_rst_n),
      .op_valid_i  (lane_op_valid[i]),
      .op_i        (lane_op[i]),
      .operand_i   (lane_operand[i]),
      .res_valid_o (lane_res_valid[i]),
      .res_o       (lane_res[i])
    );
  end

  ////////////////////////////////////////////////////////////////////////////
  // Output compare
  ////////////////////////////////////////////////////////////////////////////

  lockstep_compare u_compare (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .cmp_enable_i     (cmp_enable),
    .fault_inject_i   (fault_inject_i),
    .lane_res_valid_i (lane_res_valid),
    .lane_res_i       (lane_res),
    .alert_o          (alert_o)
  );

  // Results come from the main lane
  assign res_valid_o  = lane_res_valid[0];
  assign res_o        = lane_res[0];
  assign cmp_enable_o = cmp_enable;

endmodule

// ==== tb.f ====
+incdir+design
design/lockstep_pkg.sv
design/acc_core.sv
design/lockstep_stagger.sv
design/lockstep_reset_ctrl.sv
design/lockstep_compare.sv
design/lockstep_top.sv
verification/tb_lockstep.sv

// ==== verification/tb_lockstep.sv ====
// Testbench with clock, reset, stimulus table, reference model, random stream, checks and timeout

`timescale 1ns/1ps

`include "lockstep_settings.svh"

module tb_lockstep;

  localparam int RESET_CYCLES = 16;
  localparam int NUM_ROWS     = 16;
  localparam int NUM_RANDOM   = 200;
  localparam int MAX_GAP      = 2;
  localparam int EN_BOUND     = `LOCKSTEP_OFFSET + 2;
  localparam int DRAIN_CYCLES = `LOCKSTEP_OFFSET + 3;

  // Table, worst-case random stream, two resets with enable wait, three drains, margin
  localparam int TIMEOUT_CYCLES = NUM_ROWS + (MAX_GAP + 1) * NUM_RANDOM
                                + 2 * (RESET_CYCLES + EN_BOUND)
                                + 3 * DRAIN_CYCLES + 100;

  typedef struct {
    logic                    valid;
    lockstep_pkg::acc_op_e   op;
    lockstep_pkg::acc_data_t operand;
    logic                    inject;
    lockstep_pkg::acc_data_t expected;
  } stim_row_t;

  logic                    clk_i;
  logic                    rst_ni;
  logic                    op_valid_i;
  lockstep_pkg::acc_op_e   op_i;
  lockstep_pkg::acc_data_t operand_i;
  logic                    fault_inject_i;
  logic                    res_valid_o;
  lockstep_pkg::acc_data_t res_o;
  logic                    cmp_enable_o;
  logic                    alert_o;

  stim_row_t               stim_tbl [$];
  lockstep_pkg::acc_data_t acc_ref;
  integer                  seed;
  int                      cycle_cnt;

  lockstep_top DUT (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .op_valid_i     (op_valid_i),
    .op_i           (op_i),
    .operand_i      (operand_i),
    .fault_inject_i (fault_inject_i),
    .res_valid_o    (res_valid_o),
    .res_o          (res_o),
    .cmp_enable_o   (cmp_enable_o),
    .alert_o        (alert_o)
  );

  // 8 ns period
  always #4 clk_i = ~clk_i;

  ////////////////////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////////////////////

  task automatic end_with_failure();
    $display("Simulation finished: FAIL");
    $fatal(1);
  endtask

  task automatic compare_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
    if (actual !== expected) begin
      $display("** Error at time %0t: %s expected 0x%0h, actual 0x%0h",
               $time, name, expected, actual);
      end_with_failure();
    end
  endtask

  // Inputs change 1 ns after the rising edge
  task automatic next_cycle();
    @(posedge clk_i);
    #1;
  endtask

  task automatic drive_inputs(input logic valid, input lockstep_pkg::acc_op_e op,
                              input lockstep_pkg::acc_data_t operand, input logic inject);
    op_valid_i     = valid;
    op_i           = op;
    operand_i      = operand;
    fault_inject_i = inject;
  endtask

  task automatic verify_outputs(input logic valid, input lockstep_pkg::acc_data_t value,
                                input logic alert);
    compare_value("res_valid_o", valid, res_valid_o);
    compare_value("res_o", value, res_o);
    compare_value("alert_o", alert, alert_o);
    compare_value("cmp_enable_o", 1'b1, cmp_enable_o);
  endtask

  // Accumulator rule, wrapping at DATA_W bits
  function automatic lockstep_pkg::acc_data_t predict_acc(
    input lockstep_pkg::acc_data_t acc,
    input lockstep_pkg::acc_op_e   op,
    input lockstep_pkg::acc_data_t operand
  );
    case (op)
      lockstep_pkg::OP_CLR:  return '0;
      lockstep_pkg::OP_LOAD: return operand;
      lockstep_pkg::OP_ADD:  return acc + operand;
      lockstep_pkg::OP_SUB:  return acc - operand;
      lockstep_pkg::OP_AND:  return acc & operand;
      lockstep_pkg::OP_XOR:  return acc ^ operand;
      default:               return acc;
    endcase
  endfunction

  task automatic hold_reset();
    rst_ni = 1'b0;
    repeat (RESET_CYCLES) begin
      next_cycle();
      compare_value("res_valid_o", 1'b0, res_valid_o);
      compare_value("cmp_enable_o", 1'b0, cmp_enable_o);
      compare_value("alert_o", 1'b0, alert_o);
    end
    rst_ni = 1'b1;
  endtask

  // Enable must rise within OFFSET+2 cycles, with no result or alert before it
  task automatic wait_for_enable();
    int waited;
    waited = 0;
    while (!cmp_enable_o && waited < EN_BOUND) begin
      next_cycle();
      waited++;
      compare_value("res_valid_o", 1'b0, res_valid_o);
      compare_value("alert_o", 1'b0, alert_o);
    end
    if (!cmp_enable_o) begin
      $display("Compare enable did not rise within %0d cycles of reset release", EN_BOUND);
      end_with_failure();
    end
  endtask

  function automatic void add_row(input logic valid, input lockstep_pkg::acc_op_e op,
                                  input lockstep_pkg::acc_data_t operand, input logic inject,
                                  input lockstep_pkg::acc_data_t expected);
    stim_row_t row;
    row.valid    = valid;
    row.op       = op;
    row.operand  = operand;
    row.inject   = inject;
    row.expected = expected;
    stim_tbl.push_back(row);
  endfunction

  // Expected column worked out by hand from the opcode rules, idle rows hold
  function automatic void build_table();
    add_row(1'b1, lockstep_pkg::OP_LOAD, 16'h1234, 1'b0, 16'h1234);
    add_row(1'b1, lockstep_pkg::OP_ADD,  16'h0F0F, 1'b0, 16'h2143);
    add_row(1'b1, lockstep_pkg::OP_SUB,  16'h0143, 1'b0, 16'h2000);
    add_row(1'b0, lockstep_pkg::OP_ADD,  16'h7777, 1'b0, 16'h2000);
    add_row(1'b1, lockstep_pkg::OP_XOR,  16'hFFFF, 1'b0, 16'hDFFF);
    add_row(1'b1, lockstep_pkg::OP_AND,  16'h0FF0, 1'b0, 16'h0FF0);
    // Carry out of the top bit is dropped
    add_row(1'b1, lockstep_pkg::OP_ADD,  16'hF010, 1'b0, 16'h0000);
    add_row(1'b1, lockstep_pkg::OP_SUB,  16'h0001, 1'b0, 16'hFFFF);
    add_row(1'b1, lockstep_pkg::OP_ADD,  16'h0001, 1'b1, 16'h0000);
    add_row(1'b0, lockstep_pkg::OP_LOAD, 16'h5555, 1'b0, 16'h0000);
    add_row(1'b1, lockstep_pkg::OP_LOAD, 16'hA5A5, 1'b0, 16'hA5A5);
    add_row(1'b1, lockstep_pkg::OP_CLR,  16'hBEEF, 1'b0, 16'h0000);
    // Self-test also fires on an idle cycle
    add_row(1'b0, lockstep_pkg::OP_XOR,  16'h1111, 1'b1, 16'h0000);
    add_row(1'b1, lockstep_pkg::OP_XOR,  16'h5A5A, 1'b0, 16'h5A5A);
    add_row(1'b1, lockstep_pkg::OP_AND,  16'hFFFF, 1'b0, 16'h5A5A);
    add_row(1'b0, lockstep_pkg::OP_CLR,  16'h0000, 1'b0, 16'h5A5A);
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Timeout
  ////////////////////////////////////////////////////////////////////////////

  always @(posedge clk_i) begin
    cycle_cnt++;
    if (cycle_cnt > TIMEOUT_CYCLES) begin
      $display("Timeout after %0d cycles, the test sequence did not complete", cycle_cnt);
      end_with_failure();
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    int                      gap;
    logic [31:0]             rnd;
    lockstep_pkg::acc_op_e   op;
    lockstep_pkg::acc_data_t operand;

    clk_i     = 1'b0;
    rst_ni    = 1'b0;
    cycle_cnt = 0;
    seed      = 32'hbd8479e9;
    acc_ref   = '0;
    drive_inputs(1'b0, lockstep_pkg::OP_CLR, '0, 1'b0);
    build_table();

    // Reset state and enable release
    hold_reset();
    wait_for_enable();

    // Opcode table, alert follows the inject column by one cycle
    foreach (stim_tbl[i]) begin
      drive_inputs(stim_tbl[i].valid, stim_tbl[i].op, stim_tbl[i].operand,
                   stim_tbl[i].inject);
      next_cycle();
      verify_outputs(stim_tbl[i].valid, stim_tbl[i].expected, stim_tbl[i].inject);
    end
    acc_ref = stim_tbl[stim_tbl.size() - 1].expected;
    drive_inputs(1'b0, lockstep_pkg::OP_CLR, '0, 1'b0);
    next_cycle();
    verify_outputs(1'b0, acc_ref, 1'b0);

    // Random stream with 0 to MAX_GAP idle cycles before each operation
    for (int n = 0; n < NUM_RANDOM; n++) begin
      rnd = $random(seed);
      gap = rnd % (MAX_GAP + 1);
      repeat (gap) begin
        rnd = $random(seed);
        drive_inputs(1'b0, lockstep_pkg::OP_XOR, rnd[`DATA_W-1:0], 1'b0);
        next_cycle();
        verify_outputs(1'b0, acc_ref, 1'b0);
      end
      rnd     = $random(seed);
      op      = lockstep_pkg::acc_op_e'(rnd % 6);
      rnd     = $random(seed);
      operand = rnd[`DATA_W-1:0];
      acc_ref = predict_acc(acc_ref, op, operand);
      drive_inputs(1'b1, op, operand, 1'b0);
      next_cycle();
      verify_outputs(1'b1, acc_ref, 1'b0);
    end

    // Shadow lane catches up with no alert
    drive_inputs(1'b0, lockstep_pkg::OP_CLR, '0, 1'b0);
    repeat (DRAIN_CYCLES) begin
      next_cycle();
      verify_outputs(1'b0, acc_ref, 1'b0);
    end

    // Reset mid-run clears both lanes and drops the enable at once
    rst_ni = 1'b0;
    #1;
    compare_value("res_o", '0, res_o);
    compare_value("res_valid_o", 1'b0, res_valid_o);
    compare_value("cmp_enable_o", 1'b0, cmp_enable_o);
    compare_value("alert_o", 1'b0, alert_o);
    hold_reset();
    wait_for_enable();

    acc_ref = predict_acc('0, lockstep_pkg::OP_ADD, 16'h3C3C);
    drive_inputs(1'b1, lockstep_pkg::OP_ADD, 16'h3C3C, 1'b0);
    next_cycle();
    verify_outputs(1'b1, acc_ref, 1'b0);
    drive_inputs(1'b0, lockstep_pkg::OP_CLR, '0, 1'b0);
    repeat (DRAIN_CYCLES) begin
      next_cycle();
      verify_outputs(1'b0, acc_ref, 1'b0);
    end

    $display("Simulation finished: PASS");
    $finish;
  end

endmodule
